// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc  = 32'h0000_0000;
    // all-zero word decodes as an rtype with no known funct, so it does nothing
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0000;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic                  reg_we;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  b_imm;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_we;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_we;
        logic                  mem_rd;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
    } mem_wb_t;

    // one later stage as seen by the decode forwarding logic
    typedef struct packed {
        logic                  we;
        logic                  mem_rd;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } fwd_src_t;

endpackage

// ==== source/fetch_unit.sv ====
module fetch_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     stall,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] redirect_pc,
    input  logic [cpu_pkg::xlen-1:0] imem_rdata,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    output logic [cpu_pkg::xlen-1:0] fetch_instr,
    output logic [cpu_pkg::xlen-1:0] fetch_pc_plus4
);

    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] pc_plus4;

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // redirect is never raised together with stall by decode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= cpu_pkg::reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    // fetch/decode register, squashed after a taken branch or jump
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_instr <= cpu_pkg::nop_instr;
        end else if (redirect) begin
            fetch_instr <= cpu_pkg::nop_instr;
        end else if (!stall) begin
            fetch_instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_pc_plus4 <= pc_plus4;
        end
    end

endmodule

// ==== source/reg_file.sv ====
module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
    input  logic                           wr_en,
    input  logic [cpu_pkg::xlen-1:0]       wr_data,
    output logic [cpu_pkg::xlen-1:0]       rs_data,
    output logic [cpu_pkg::xlen-1:0]       rt_data
);

    logic [cpu_pkg::xlen-1:0] regs [1:31];

    // register 0 is hardwired, a same-cycle write is passed straight through
    function automatic logic [cpu_pkg::xlen-1:0] read_port(
        input logic [cpu_pkg::reg_addr_w-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [cpu_pkg::xlen-1:0]       fetch_instr,
    input  logic [cpu_pkg::xlen-1:0]       fetch_pc_plus4,
    input  logic [cpu_pkg::xlen-1:0]       rs_data,
    input  logic [cpu_pkg::xlen-1:0]       rt_data,
    input  cpu_pkg::fwd_src_t              ex_fwd,
    input  cpu_pkg::fwd_src_t              mem_fwd,
    output logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    output logic                           stall,
    output logic                           redirect,
    output logic [cpu_pkg::xlen-1:0]       redirect_pc,
    output cpu_pkg::id_ex_t                id_ex
);

    cpu_pkg::opcode_e               opcode;
    cpu_pkg::funct_e                funct;
    cpu_pkg::alu_op_e               alu_op;
    cpu_pkg::id_ex_t                id_ex_d;
    logic [cpu_pkg::reg_addr_w-1:0] dest;
    logic [cpu_pkg::xlen-1:0]       imm_ext;
    logic [cpu_pkg::xlen-1:0]       rs_val;
    logic [cpu_pkg::xlen-1:0]       rt_val;
    logic [cpu_pkg::xlen-1:0]       branch_target;
    logic [cpu_pkg::xlen-1:0]       jump_target;
    logic                           valid_op;
    logic                           reg_we;
    logic                           mem_rd;
    logic                           mem_wr;
    logic                           b_imm;
    logic                           use_rs;
    logic                           use_rt;
    logic                           is_beq;
    logic                           is_j;
    logic                           taken;

    assign opcode  = cpu_pkg::opcode_e'(fetch_instr[31:26]);
    assign funct   = cpu_pkg::funct_e'(fetch_instr[5:0]);
    assign rs_addr = fetch_instr[25:21];
    assign rt_addr = fetch_instr[20:16];
    assign imm_ext = {{16{fetch_instr[15]}}, fetch_instr[15:0]};

    always_comb begin
        valid_op = 1'b0;
        reg_we   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        b_imm    = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        is_beq   = 1'b0;
        is_j     = 1'b0;
        alu_op   = cpu_pkg::alu_add;
        dest     = rt_addr;
        case (opcode)
            cpu_pkg::op_rtype: begin
                dest     = fetch_instr[15:11];
                valid_op = 1'b1;
                reg_we   = 1'b1;
                use_rs   = 1'b1;
                use_rt   = 1'b1;
                case (funct)
                    cpu_pkg::fn_add: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:  alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_slt: alu_op = cpu_pkg::alu_slt;
                    default: begin
                        // unknown funct, including the bubble word
                        valid_op = 1'b0;
                        reg_we   = 1'b0;
                        use_rs   = 1'b0;
                        use_rt   = 1'b0;
                    end
                endcase
            end
            cpu_pkg::op_addi: begin
                valid_op = 1'b1;
                reg_we   = 1'b1;
                b_imm    = 1'b1;
                use_rs   = 1'b1;
            end
            cpu_pkg::op_lw: begin
                valid_op = 1'b1;
                reg_we   = 1'b1;
                mem_rd   = 1'b1;
                b_imm    = 1'b1;
                use_rs   = 1'b1;
            end
            cpu_pkg::op_sw: begin
                valid_op = 1'b1;
                mem_wr   = 1'b1;
                b_imm    = 1'b1;
                use_rs   = 1'b1;
                use_rt   = 1'b1;
            end
            cpu_pkg::op_beq: begin
                is_beq = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            cpu_pkg::op_j: begin
                is_j = 1'b1;
            end
            default: ;
        endcase
    end

    // execute first (not a load), then memory, then the register file
    function automatic logic [cpu_pkg::xlen-1:0] forward(
        input logic [cpu_pkg::reg_addr_w-1:0] addr,
        input logic [cpu_pkg::xlen-1:0]       rf_data
    );
        if (addr == '0) begin
            return rf_data;
        end else if (ex_fwd.we && !ex_fwd.mem_rd && ex_fwd.rd == addr) begin
            return ex_fwd.data;
        end else if (mem_fwd.we && mem_fwd.rd == addr) begin
            return mem_fwd.data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_val = forward(rs_addr, rs_data);
        rt_val = forward(rt_addr, rt_data);
    end

    // load in execute feeding this instruction
    assign stall = ex_fwd.we && ex_fwd.mem_rd && ex_fwd.rd != '0
                   && ((use_rs && ex_fwd.rd == rs_addr) || (use_rt && ex_fwd.rd == rt_addr));

    assign branch_target = fetch_pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {fetch_pc_plus4[31:28], fetch_instr[25:0], 2'b00};
    assign taken         = is_beq && (rs_val == rt_val);
    assign redirect      = !stall && (taken || is_j);
    assign redirect_pc   = is_j ? jump_target : branch_target;

    always_comb begin
        id_ex_d.valid  = valid_op;
        id_ex_d.reg_we = reg_we;
        id_ex_d.mem_rd = mem_rd;
        id_ex_d.mem_wr = mem_wr;
        id_ex_d.b_imm  = b_imm;
        id_ex_d.alu_op = alu_op;
        id_ex_d.rd     = dest;
        id_ex_d.op_a   = rs_val;
        id_ex_d.op_b   = rt_val;
        id_ex_d.imm    = imm_ext;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_pkg::id_ex_t          id_ex,
    output cpu_pkg::ex_mem_t         ex_mem,
    output logic [cpu_pkg::xlen-1:0] ex_result
);

    logic [cpu_pkg::xlen-1:0] alu_a;
    logic [cpu_pkg::xlen-1:0] alu_b;
    logic                     less;

    assign alu_a = id_ex.op_a;
    assign alu_b = id_ex.b_imm ? id_ex.imm : id_ex.op_b;
    assign less  = $signed(alu_a) < $signed(alu_b);

    // wrapping arithmetic, no overflow trap
    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_add: ex_result = alu_a + alu_b;
            cpu_pkg::alu_sub: ex_result = alu_a - alu_b;
            cpu_pkg::alu_and: ex_result = alu_a & alu_b;
            cpu_pkg::alu_or:  ex_result = alu_a | alu_b;
            cpu_pkg::alu_slt: ex_result = {{(cpu_pkg::xlen-1){1'b0}}, less};
            default:          ex_result = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.mem_rd     <= id_ex.mem_rd;
            ex_mem.mem_wr     <= id_ex.mem_wr;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= ex_result;
            // rt value, already forwarded in decode
            ex_mem.store_data <= id_ex.op_b;
        end
    end

endmodule

// ==== source/mem_wb_stage.sv ====
module mem_wb_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  cpu_pkg::ex_mem_t               ex_mem,
    input  logic [cpu_pkg::xlen-1:0]       dmem_rdata,
    output logic [cpu_pkg::xlen-1:0]       dmem_addr,
    output logic [cpu_pkg::xlen-1:0]       dmem_wdata,
    output logic                           dmem_we,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::xlen-1:0]       wb_data,
    output logic                           wb_en
);

    cpu_pkg::mem_wb_t mem_wb;

    // data memory reads combinationally, writes on the clock edge
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.mem_wr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_we     <= ex_mem.valid && ex_mem.reg_we;
            mem_wb.mem_rd     <= ex_mem.mem_rd;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dmem_rdata;
        end
    end

    assign wb_addr = mem_wb.rd;
    assign wb_en   = mem_wb.reg_we;
    assign wb_data = mem_wb.mem_rd ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== source/pipeline_cpu.sv ====
module pipeline_cpu (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [cpu_pkg::xlen-1:0] imem_rdata,
    input  logic [cpu_pkg::xlen-1:0] dmem_rdata,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_wdata,
    output logic                     dmem_we
);

    logic [cpu_pkg::xlen-1:0]       fetch_instr;
    logic [cpu_pkg::xlen-1:0]       fetch_pc_plus4;
    logic                           stall;
    logic                           redirect;
    logic [cpu_pkg::xlen-1:0]       redirect_pc;
    logic [cpu_pkg::reg_addr_w-1:0] rs_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rt_addr;
    logic [cpu_pkg::xlen-1:0]       rs_data;
    logic [cpu_pkg::xlen-1:0]       rt_data;
    logic [cpu_pkg::reg_addr_w-1:0] wb_addr;
    logic [cpu_pkg::xlen-1:0]       wb_data;
    logic                           wb_en;
    logic [cpu_pkg::xlen-1:0]       ex_result;
    cpu_pkg::id_ex_t                id_ex;
    cpu_pkg::ex_mem_t               ex_mem;
    cpu_pkg::fwd_src_t              ex_fwd;
    cpu_pkg::fwd_src_t              mem_fwd;

    // execute result is the live ALU output
    assign ex_fwd.we     = id_ex.valid && id_ex.reg_we;
    assign ex_fwd.mem_rd = id_ex.mem_rd;
    assign ex_fwd.rd     = id_ex.rd;
    assign ex_fwd.data   = ex_result;

    // memory stage result picks the load data for a lw
    assign mem_fwd.we     = ex_mem.valid && ex_mem.reg_we;
    assign mem_fwd.mem_rd = ex_mem.mem_rd;
    assign mem_fwd.rd     = ex_mem.rd;
    assign mem_fwd.data   = ex_mem.mem_rd ? dmem_rdata : ex_mem.alu_result;

    fetch_unit i_fetch (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .imem_rdata     (imem_rdata),
        .imem_addr      (imem_addr),
        .fetch_instr    (fetch_instr),
        .fetch_pc_plus4 (fetch_pc_plus4)
    );

    decode_stage i_decode (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_instr    (fetch_instr),
        .fetch_pc_plus4 (fetch_pc_plus4),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .id_ex          (id_ex)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wb_addr),
        .wr_en   (wb_en),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage i_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .ex_result (ex_result)
    );

    mem_wb_stage i_mem_wb (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .wb_en      (wb_en)
    );

endmodule

// ==== verif/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// MIPS field layout
function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd, input int rs,
                                       input int rt);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
                                       input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic logic [31:0] j_word(input int index);
    return {6'h02, index[25:0]};
endfunction

function automatic void emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
endfunction

// low 16 words random and the rest tagged with their own address
task automatic seed_data_memory();
    for (int i = 0; i < 64; i++) begin
        if (i < 16) begin
            dmem[i] = $urandom();
        end else begin
            dmem[i] = 32'hc0de_0000 | (i << 2);
        end
    end
endtask

task automatic load_program();
    for (int i = 0; i < 64; i++) begin
        imem[i] = '0;
    end
    prog_len = 0;
    // load feeding an add right away
    emit(i_word(cpu_pkg::op_lw, 1, 0, 0));
    emit(i_word(cpu_pkg::op_lw, 2, 0, 4));
    emit(r_word(cpu_pkg::fn_add, 3, 1, 2));
    emit(i_word(cpu_pkg::op_sw, 3, 0, 'h80));
    emit(r_word(cpu_pkg::fn_sub, 4, 1, 2));
    emit(i_word(cpu_pkg::op_sw, 4, 0, 'h84));
    emit(r_word(cpu_pkg::fn_and, 5, 1, 2));
    emit(r_word(cpu_pkg::fn_or, 6, 1, 2));
    emit(i_word(cpu_pkg::op_sw, 5, 0, 'h88));
    emit(i_word(cpu_pkg::op_sw, 6, 0, 'h8c));
    // negative immediate and signed compares
    emit(i_word(cpu_pkg::op_addi, 7, 0, -5));
    emit(i_word(cpu_pkg::op_addi, 8, 0, 3));
    emit(r_word(cpu_pkg::fn_slt, 9, 7, 8));
    emit(r_word(cpu_pkg::fn_slt, 10, 8, 7));
    emit(i_word(cpu_pkg::op_sw, 9, 0, 'h90));
    emit(i_word(cpu_pkg::op_sw, 10, 0, 'h94));
    emit(r_word(cpu_pkg::fn_sub, 11, 7, 1));
    emit(r_word(cpu_pkg::fn_and, 12, 7, 2));
    emit(r_word(cpu_pkg::fn_or, 13, 7, 2));
    emit(r_word(cpu_pkg::fn_slt, 14, 1, 2));
    emit(i_word(cpu_pkg::op_sw, 11, 0, 'h98));
    emit(i_word(cpu_pkg::op_sw, 12, 0, 'h9c));
    emit(i_word(cpu_pkg::op_sw, 13, 0, 'ha0));
    emit(i_word(cpu_pkg::op_sw, 14, 0, 'ha4));
    // dependent chain on negative operands
    emit(i_word(cpu_pkg::op_addi, 15, 7, -100));
    emit(r_word(cpu_pkg::fn_add, 16, 15, 15));
    emit(r_word(cpu_pkg::fn_sub, 17, 16, 15));
    emit(i_word(cpu_pkg::op_sw, 17, 0, 'ha8));
    // store of a just-loaded register
    emit(i_word(cpu_pkg::op_lw, 18, 0, 8));
    emit(i_word(cpu_pkg::op_sw, 18, 0, 'hac));
    emit(i_word(cpu_pkg::op_addi, 19, 0, 'h40));
    emit(i_word(cpu_pkg::op_lw, 20, 0, 12));
    emit(i_word(cpu_pkg::op_sw, 20, 19, 'h70));
    // the slot after each taken branch or jump holds a store that must never show up
    emit(i_word(cpu_pkg::op_beq, 1, 1, 1));
    emit(i_word(cpu_pkg::op_sw, 1, 0, 'hc0));
    emit(i_word(cpu_pkg::op_beq, 8, 7, 1));
    emit(i_word(cpu_pkg::op_sw, 7, 0, 'hb4));
    emit(i_word(cpu_pkg::op_addi, 21, 7, 8));
    emit(i_word(cpu_pkg::op_beq, 8, 21, 1));
    emit(i_word(cpu_pkg::op_sw, 8, 0, 'hc4));
    emit(j_word(42));
    emit(i_word(cpu_pkg::op_sw, 2, 0, 'hc8));
    emit(i_word(cpu_pkg::op_sw, 16, 0, 'hb8));
    emit(j_word(43));
endtask

// instruction-set model that returns the executed count or -1 on a runaway program
function automatic int run_reference();
    logic [31:0] regs [0:31];
    logic [31:0] mem [0:63];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] instr;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    int          count;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mem[i] = dmem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    pc    = '0;
    count = 0;
    while (count < 1000) begin
        instr   = imem[pc[7:2]];
        a       = regs[instr[25:21]];
        b       = regs[instr[20:16]];
        imm     = {{16{instr[15]}}, instr[15:0]};
        next_pc = pc + 32'd4;
        count++;
        case (instr[31:26])
            6'h00: begin
                case (instr[5:0])
                    6'h20: regs[instr[15:11]] = a + b;
                    6'h22: regs[instr[15:11]] = a - b;
                    6'h24: regs[instr[15:11]] = a & b;
                    6'h25: regs[instr[15:11]] = a | b;
                    6'h2a: regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            6'h08: regs[instr[20:16]] = a + imm;
            6'h23: begin
                addr = a + imm;
                regs[instr[20:16]] = mem[addr[7:2]];
            end
            6'h2b: begin
                addr = a + imm;
                mem[addr[7:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            6'h04: begin
                if (a == b) begin
                    next_pc = pc + 32'd4 + (imm << 2);
                end
            end
            6'h02: begin
                next_pc = {next_pc[31:28], instr[25:0], 2'b00};
                // self-jump ends the program
                if (next_pc == pc) begin
                    return count;
                end
            end
            default: ;
        endcase
        regs[0] = '0;
        pc      = next_pc;
    end
    return -1;
endfunction

`endif

// ==== verif/tb_pipeline_cpu.sv ====
module tb_pipeline_cpu;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          prog_len;
    int          ref_count;
    int          cycle_limit;
    int          cycles;
    int          store_idx;
    bit          running;

    `include "tb_program.svh"

    pipeline_cpu i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we)
    );

    always #2 clk = ~clk;

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, expected);
            end_with_failure();
        end
    endtask

    // memories answer on the falling edge, addresses only move on the rising one
    always @(negedge clk) begin
        imem_rdata <= imem[imem_addr[7:2]];
        dmem_rdata <= dmem[dmem_addr[7:2]];
    end

    always @(posedge clk) begin
        if (arst_n && dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // store monitor
    always @(negedge clk) begin
        if (running && dmem_we) begin
            if (store_idx >= exp_addr.size()) begin
                report_failure($sformatf("extra store to address 0x%08h after all %0d expected",
                                         dmem_addr, exp_addr.size()));
            end else begin
                check_value($sformatf("store %0d address", store_idx), dmem_addr,
                            exp_addr[store_idx]);
                check_value($sformatf("store %0d data", store_idx), dmem_wdata,
                            exp_data[store_idx]);
                store_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > cycle_limit) begin
                report_failure($sformatf("timeout after %0d cycles, %0d of %0d stores seen",
                                         cycles, store_idx, exp_addr.size()));
            end
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        running    = 1'b0;
        cycles     = 0;
        store_idx  = 0;
        void'($urandom(32'h49dd_a599));
        seed_data_memory();
        load_program();
        ref_count = run_reference();
        if (ref_count < 0) begin
            report_failure("reference model never reached the final self-jump");
        end
        if (exp_addr.size() == 0) begin
            report_failure("reference model produced no stores");
        end
        cycle_limit = 4 * ref_count + 50;

        repeat (8) begin
            @(negedge clk);
            if (dmem_we !== 1'b0) begin
                report_failure("store enable not low during reset");
            end
        end
        arst_n  = 1'b1;
        running = 1'b1;

        wait (store_idx == exp_addr.size());
        // a few more cycles so a late stray store is still caught
        repeat (10) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verif
source/cpu_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/pipeline_cpu.sv
verif/tb_pipeline_cpu.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

sources:
  - files:
      - source/cpu_pkg.sv
      - source/fetch_unit.sv
      - source/reg_file.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/mem_wb_stage.sv
      - source/pipeline_cpu.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_pipeline_cpu.sv
